// ==== Makefile ====
# Verilator build and run for the SoC peripheral domain

VERILATOR ?= verilator
TOP       ?= tb_soc_domain
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
FILELIST  ?= compile.f

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard verif/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^Result: PASSED$$'

clean:
	rm -rf $(BUILD_DIR)

// ==== common/soc_pkg.sv ====
package soc_pkg;

  // --------------------------------------------------------------------------
  // Bus widths and channel structs
  // --------------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [StrbWidth-1:0] be;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic                 gnt;
    logic                 rvalid;
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } bus_rsp_t;

  // Subordinate select, index into the demux port arrays
  typedef enum logic [2:0] {
    SbrError   = 3'd0,
    SbrSram    = 3'd1,
    SbrSocCtrl = 3'd2,
    SbrGpio    = 3'd3,
    SbrTimer   = 3'd4
  } sbr_idx_e;

  localparam int unsigned NumSbr = 5;

  // --------------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------------
  localparam logic [AddrWidth-1:0] SramBaseAddr    = 32'h1000_0000;
  localparam int unsigned          SramNumWords    = 1024;
  localparam int unsigned          SramIdxWidth    = $clog2(SramNumWords);
  localparam logic [AddrWidth-1:0] SramSize        = AddrWidth'(SramNumWords * StrbWidth);
  localparam logic [AddrWidth-1:0] SocCtrlBaseAddr = 32'h0300_0000;
  localparam logic [AddrWidth-1:0] GpioBaseAddr    = 32'h0300_5000;
  localparam logic [AddrWidth-1:0] TimerBaseAddr   = 32'h0300_A000;
  localparam logic [AddrWidth-1:0] PeriphSize      = 32'h0000_1000;
  localparam int unsigned          RegOffsetWidth  = $clog2(PeriphSize);

  localparam logic [DataWidth-1:0] ErrRspData = 32'hBADC_AB1E;

  // --------------------------------------------------------------------------
  // Pins and interrupts
  // --------------------------------------------------------------------------
  localparam int unsigned GpioCount       = 16;
  localparam int unsigned NumExternalIrqs = 4;
  localparam int unsigned NumIrqs         = 16;
  localparam int unsigned IrqTimer        = 0;
  localparam int unsigned IrqGpio         = 1;
  localparam int unsigned IrqExtBase      = 2;

  // Register word offsets inside each peripheral region
  localparam logic [RegOffsetWidth-1:0] SocCtrlBootAddrOffset = 'h0;
  localparam logic [RegOffsetWidth-1:0] SocCtrlFetchEnOffset  = 'h4;
  localparam logic [RegOffsetWidth-1:0] GpioDirOffset         = 'h0;
  localparam logic [RegOffsetWidth-1:0] GpioOutOffset         = 'h4;
  localparam logic [RegOffsetWidth-1:0] GpioInOffset          = 'h8;
  localparam logic [RegOffsetWidth-1:0] GpioIrqEnOffset       = 'hC;
  localparam logic [RegOffsetWidth-1:0] GpioIrqStatusOffset   = 'h10;
  localparam logic [RegOffsetWidth-1:0] TimerCntOffset        = 'h0;
  localparam logic [RegOffsetWidth-1:0] TimerCmpOffset        = 'h4;
  localparam logic [RegOffsetWidth-1:0] TimerCtrlOffset       = 'h8;

  // Expand byte enables into a bit mask over the data word
  function automatic logic [DataWidth-1:0] be_to_mask(input logic [StrbWidth-1:0] be);
    logic [DataWidth-1:0] mask;
    for (int unsigned b = 0; b < StrbWidth; b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return mask;
  endfunction

endpackage

// ==== compile.f ====
+incdir+verif
common/soc_pkg.sv
verilog/err_sbr.sv
verilog/sram_bank.sv
verilog/soc_ctrl.sv
gpio/gpio.sv
timer/timer_unit.sv
verilog/periph_demux.sv
verilog/soc_domain.sv
verif/tb_soc_domain.sv

// ==== gpio/gpio.sv ====
module gpio import soc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  bus_req_t             req_i,
  output bus_rsp_t             rsp_o,
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,
  output logic [GpioCount-1:0] gpio_in_sync_o,
  output logic                 irq_o
);

  logic [RegOffsetWidth-1:0] offset;
  logic [DataWidth-1:0]      wmask;
  logic [DataWidth-1:0]      wbits;
  logic                      wr_en;
  logic [GpioCount-1:0]      sync1_q;
  logic [GpioCount-1:0]      sync2_q;
  logic [GpioCount-1:0]      prev_q;
  logic [GpioCount-1:0]      dir_q;
  logic [GpioCount-1:0]      out_q;
  logic [GpioCount-1:0]      irq_en_q;
  logic [GpioCount-1:0]      status_q;
  logic [GpioCount-1:0]      rise;
  logic [GpioCount-1:0]      status_clr;
  logic [DataWidth-1:0]      read_data;
  logic [DataWidth-1:0]      rdata_q;
  logic                      rvalid_q;

  assign offset = req_i.addr[RegOffsetWidth-1:0];
  assign wmask  = be_to_mask(req_i.be);
  assign wbits  = req_i.wdata & wmask;
  assign wr_en  = req_i.req & req_i.we;

  // --------------------------------------------------------------------------
  // Input sync and edge detect
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  assign rise       = sync2_q & ~prev_q;
  // Write one to clear
  assign status_clr = (wr_en && offset == GpioIrqStatusOffset) ? wbits[GpioCount-1:0] : '0;

  // --------------------------------------------------------------------------
  // Registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      irq_en_q <= '0;
      status_q <= '0;
    end else begin
      if (wr_en && offset == GpioDirOffset) begin
        dir_q <= (dir_q & ~wmask[GpioCount-1:0]) | wbits[GpioCount-1:0];
      end
      if (wr_en && offset == GpioOutOffset) begin
        out_q <= (out_q & ~wmask[GpioCount-1:0]) | wbits[GpioCount-1:0];
      end
      if (wr_en && offset == GpioIrqEnOffset) begin
        irq_en_q <= (irq_en_q & ~wmask[GpioCount-1:0]) | wbits[GpioCount-1:0];
      end
      // A new edge wins over a clear in the same cycle
      status_q <= (status_q & ~status_clr) | (rise & irq_en_q);
    end
  end

  always_comb begin
    case (offset)
      GpioDirOffset:       read_data = DataWidth'(dir_q);
      GpioOutOffset:       read_data = DataWidth'(out_q);
      GpioInOffset:        read_data = DataWidth'(sync2_q);
      GpioIrqEnOffset:     read_data = DataWidth'(irq_en_q);
      GpioIrqStatusOffset: read_data = DataWidth'(status_q);
      default:             read_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) rdata_q <= req_i.we ? '0 : read_data;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) rvalid_q <= 1'b0;
    else          rvalid_q <= req_i.req;
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = 1'b0;

  assign gpio_o         = out_q;
  assign gpio_out_en_o  = dir_q;
  assign gpio_in_sync_o = sync2_q;
  assign irq_o          = |status_q;

endmodule

// ==== timer/timer_unit.sv ====
module timer_unit import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o,
  output logic     irq_o
);

  logic [RegOffsetWidth-1:0] offset;
  logic [DataWidth-1:0]      wmask;
  logic                      wr_en;
  logic [DataWidth-1:0]      cnt_q;
  logic [DataWidth-1:0]      cmp_q;
  logic                      enable_q;
  logic                      hit;
  logic                      irq_q;
  logic [DataWidth-1:0]      read_data;
  logic [DataWidth-1:0]      rdata_q;
  logic                      rvalid_q;

  assign offset = req_i.addr[RegOffsetWidth-1:0];
  assign wmask  = be_to_mask(req_i.be);
  assign wr_en  = req_i.req & req_i.we;

  // Compare match while running
  assign hit = enable_q && (cnt_q == cmp_q);

  // --------------------------------------------------------------------------
  // Counter and compare
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q    <= '0;
      cmp_q    <= '0;
      enable_q <= 1'b0;
      irq_q    <= 1'b0;
    end else begin
      irq_q <= hit;
      // Bus write to Cnt beats the increment
      if (wr_en && offset == TimerCntOffset) begin
        cnt_q <= (cnt_q & ~wmask) | (req_i.wdata & wmask);
      end else if (hit) begin
        cnt_q <= '0;
      end else if (enable_q) begin
        cnt_q <= cnt_q + 1'b1;
      end
      if (wr_en && offset == TimerCmpOffset) begin
        cmp_q <= (cmp_q & ~wmask) | (req_i.wdata & wmask);
      end
      if (wr_en && offset == TimerCtrlOffset && req_i.be[0]) begin
        enable_q <= req_i.wdata[0];
      end
    end
  end

  always_comb begin
    case (offset)
      TimerCntOffset:  read_data = cnt_q;
      TimerCmpOffset:  read_data = cmp_q;
      TimerCtrlOffset: read_data = DataWidth'(enable_q);
      default:         read_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) rdata_q <= req_i.we ? '0 : read_data;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) rvalid_q <= 1'b0;
    else          rvalid_q <= req_i.req;
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = 1'b0;

  assign irq_o = irq_q;

endmodule

// ==== verif/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef enum logic [1:0] {
  OpIdle,
  OpRead,
  OpWrite
} op_e;

// Which side output an entry checks besides the bus response and irqs_o
typedef enum logic [2:0] {
  ObsNone,
  ObsGpioOut,
  ObsGpioEn,
  ObsGpioSync,
  ObsBootAddr,
  ObsFetchEn
} obs_e;

typedef struct packed {
  op_e                        op;
  logic [AddrWidth-1:0]       addr;
  logic [DataWidth-1:0]       wdata;
  logic [StrbWidth-1:0]       be;
  logic [GpioCount-1:0]       gpio_in;
  logic [NumExternalIrqs-1:0] irq_in;
  logic                       fetch_en;
  logic [DataWidth-1:0]       exp_rdata;
  logic                       exp_err;
  obs_e                       obs;
  logic [DataWidth-1:0]       exp_obs;
  logic [NumIrqs-1:0]         exp_irqs;
} vec_t;

localparam int unsigned NumVectors = 42;

// Columns: op, addr, wdata, be, gpio_i, irq_i, fetch_en_i,
//          rdata, err, observed output, its value, irqs_o
vec_t vectors [NumVectors] = '{
  // SoC control after reset, then boot address and fetch enable
  '{OpRead,  'h0300_0000, 'h0, 'h0, 'h0, 'h0, 1, 'h1000_0000, 0, ObsFetchEn, 'h1, 'h0},
  '{OpRead,  'h0300_0004, 'h0, 'h0, 'h0, 'h0, 0, 'h0, 0, ObsFetchEn, 'h0, 'h0},
  '{OpWrite, 'h0300_0000, 'h1000_0080, 'hF, 'h0, 'h0, 0, 'h0, 0, ObsBootAddr, 'h1000_0080, 'h0},
  '{OpWrite, 'h0300_0004, 'h1, 'h1, 'h0, 'h0, 0, 'h0, 0, ObsFetchEn, 'h1, 'h0},
  '{OpRead,  'h0300_0004, 'h0, 'h0, 'h0, 'h0, 0, 'h1, 0, ObsFetchEn, 'h1, 'h0},
  '{OpWrite, 'h0300_0004, 'h0, 'hF, 'h0, 'h0, 0, 'h0, 0, ObsFetchEn, 'h0, 'h0},
  // SRAM full and partial writes, then read back the merged words
  '{OpWrite, 'h1000_0000, 'h1122_3344, 'hF, 'h0, 'h0, 0, 'h0, 0, ObsNone, 'h0, 'h0},
  '{OpWrite, 'h1000_0004, 'hAABB_CCDD, 'hF, 'h0, 'h0, 0, 'h0, 0, ObsNone, 'h0, 'h0},
  '{OpWrite, 'h1000_0000, 'h0000_EE00, 'h2, 'h0, 'h0, 0, 'h0, 0, ObsNone, 'h0, 'h0},
  '{OpWrite, 'h1000_0004, 'h5566_0000, 'hC, 'h0, 'h0, 0, 'h0, 0, ObsNone, 'h0, 'h0},
  '{OpRead,  'h1000_0000, 'h0, 'h0, 'h0, 'h0, 0, 'h1122_EE44, 0, ObsNone, 'h0, 'h0},
  '{OpRead,  'h1000_0004, 'h0, 'h0, 'h0, 'h0, 0, 'h5566_CCDD, 0, ObsNone, 'h0, 'h0},
  '{OpWrite, 'h1000_0FFC, 'hCAFE_F00D, 'hF, 'h0, 'h0, 0, 'h0, 0, ObsNone, 'h0, 'h0},
  '{OpRead,  'h1000_0FFC, 'h0, 'h0, 'h0, 'h0, 0, 'hCAFE_F00D, 0, ObsNone, 'h0, 'h0},
  // Unmapped accesses, each followed by a mapped one
  '{OpRead,  'h0000_0000, 'h0, 'h0, 'h0, 'h0, 0, 'hBADC_AB1E, 1, ObsNone, 'h0, 'h0},
  '{OpRead,  'h1000_0000, 'h0, 'h0, 'h0, 'h0, 0, 'h1122_EE44, 0, ObsNone, 'h0, 'h0},
  '{OpWrite, 'h0300_2000, 'h1234, 'hF, 'h0, 'h0, 0, 'hBADC_AB1E, 1, ObsNone, 'h0, 'h0},
  '{OpRead,  'h0300_A000, 'h0, 'h0, 'h0, 'h0, 0, 'h0, 0, ObsNone, 'h0, 'h0},
  '{OpRead,  'h1000_1000, 'h0, 'h0, 'h0, 'h0, 0, 'hBADC_AB1E, 1, ObsNone, 'h0, 'h0},
  '{OpRead,  'h1000_0004, 'h0, 'h0, 'h0, 'h0, 0, 'h5566_CCDD, 0, ObsNone, 'h0, 'h0},
  // GPIO direction and output pins
  '{OpWrite, 'h0300_5000, 'h00FF, 'hF, 'h0, 'h0, 0, 'h0, 0, ObsGpioEn, 'h00FF, 'h0},
  '{OpWrite, 'h0300_5004, 'h00A5, 'hF, 'h0, 'h0, 0, 'h0, 0, ObsGpioOut, 'h00A5, 'h0},
  '{OpRead,  'h0300_5000, 'h0, 'h0, 'h0, 'h0, 0, 'h00FF, 0, ObsGpioOut, 'h00A5, 'h0},
  // GPIO input sync, rising edge on pin 0, write one to clear
  '{OpWrite, 'h0300_500C, 'h0001, 'hF, 'h0, 'h0, 0, 'h0, 0, ObsNone, 'h0, 'h0},
  '{OpIdle,  'h0, 'h0, 'h0, 'h8001, 'h0, 0, 'h0, 0, ObsGpioSync, 'h0, 'h0},
  '{OpIdle,  'h0, 'h0, 'h0, 'h8001, 'h0, 0, 'h0, 0, ObsGpioSync, 'h8001, 'h0},
  '{OpRead,  'h0300_5008, 'h0, 'h0, 'h8001, 'h0, 0, 'h8001, 0, ObsGpioSync, 'h8001, 'h2},
  '{OpRead,  'h0300_5010, 'h0, 'h0, 'h8001, 'h0, 0, 'h0001, 0, ObsNone, 'h0, 'h2},
  '{OpWrite, 'h0300_5010, 'h0001, 'hF, 'h8001, 'h0, 0, 'h0, 0, ObsNone, 'h0, 'h0},
  '{OpRead,  'h0300_5010, 'h0, 'h0, 'h8001, 'h0, 0, 'h0, 0, ObsNone, 'h0, 'h0},
  // Timer with Cmp 3, one pulse four cycles after enable, then stopped
  '{OpWrite, 'h0300_A004, 'h3, 'hF, 'h8001, 'h0, 0, 'h0, 0, ObsNone, 'h0, 'h0},
  '{OpWrite, 'h0300_A008, 'h1, 'hF, 'h8001, 'h0, 0, 'h0, 0, ObsNone, 'h0, 'h0},
  '{OpIdle,  'h0, 'h0, 'h0, 'h8001, 'h0, 0, 'h0, 0, ObsNone, 'h0, 'h0},
  '{OpIdle,  'h0, 'h0, 'h0, 'h8001, 'h0, 0, 'h0, 0, ObsNone, 'h0, 'h0},
  '{OpIdle,  'h0, 'h0, 'h0, 'h8001, 'h0, 0, 'h0, 0, ObsNone, 'h0, 'h0},
  '{OpIdle,  'h0, 'h0, 'h0, 'h8001, 'h0, 0, 'h0, 0, ObsNone, 'h0, 'h1},
  '{OpIdle,  'h0, 'h0, 'h0, 'h8001, 'h0, 0, 'h0, 0, ObsNone, 'h0, 'h0},
  '{OpWrite, 'h0300_A008, 'h0, 'hF, 'h8001, 'h0, 0, 'h0, 0, ObsNone, 'h0, 'h0},
  '{OpRead,  'h0300_A000, 'h0, 'h0, 'h8001, 'h0, 0, 'h2, 0, ObsNone, 'h0, 'h0},
  // External lines land at IrqExtBase
  '{OpIdle,  'h0, 'h0, 'h0, 'h8001, 'hA, 0, 'h0, 0, ObsNone, 'h0, 'h0028},
  '{OpIdle,  'h0, 'h0, 'h0, 'h8001, 'h5, 0, 'h0, 0, ObsNone, 'h0, 'h0014},
  '{OpIdle,  'h0, 'h0, 'h0, 'h8001, 'h0, 0, 'h0, 0, ObsNone, 'h0, 'h0}
};

`endif

// ==== verif/tb_soc_domain.sv ====
module tb_soc_domain import soc_pkg::*; ();

  localparam int unsigned ClkPeriod      = 8;
  localparam int unsigned DriveDelay     = 1;
  localparam int unsigned ResetCycles    = 4;
  localparam int unsigned RandomSeed     = 28813;
  localparam int unsigned NumRandomWords = 8;

  `include "tb_vectors.svh"

  // Four entries per random SRAM word
  localparam int unsigned TimeoutCycles = 4 * (NumVectors + 4 * NumRandomWords) + 200;

  logic                       clk_i;
  logic                       rst_n_i;
  logic                       fetch_en_i;
  bus_req_t                   bus_req;
  bus_rsp_t                   bus_rsp;
  logic [GpioCount-1:0]       gpio_i;
  logic [GpioCount-1:0]       gpio_o;
  logic [GpioCount-1:0]       gpio_out_en_o;
  logic [GpioCount-1:0]       gpio_in_sync_o;
  logic [AddrWidth-1:0]       boot_addr_o;
  logic                       fetch_enable_o;
  logic [NumExternalIrqs-1:0] irq_i;
  logic [NumIrqs-1:0]         irqs_o;

  int unsigned cycle_count = 0;

  soc_domain UUT (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fetch_en_i     (fetch_en_i),
    .bus_req_i      (bus_req),
    .bus_rsp_o      (bus_rsp),
    .gpio_i         (gpio_i),
    .gpio_o         (gpio_o),
    .gpio_out_en_o  (gpio_out_en_o),
    .gpio_in_sync_o (gpio_in_sync_o),
    .boot_addr_o    (boot_addr_o),
    .fetch_enable_o (fetch_enable_o),
    .irq_i          (irq_i),
    .irqs_o         (irqs_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TimeoutCycles) begin
      $display("Timeout after %0d cycles, the vector loop never finished", cycle_count);
      $display("Result: FAILED");
      $fatal(1, "simulation timeout");
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic report_mismatch(input string name, input logic [DataWidth-1:0] expected,
                                 input logic [DataWidth-1:0] actual);
    $display("Mismatch at time %0t: %s expected 0x%08h, got 0x%08h",
             $time, name, expected, actual);
    $display("Result: FAILED");
    $fatal(1, "check failed");
  endtask

  function automatic logic [DataWidth-1:0] merge_bytes(input logic [DataWidth-1:0] old_word,
                                                       input logic [DataWidth-1:0] new_word,
                                                       input logic [StrbWidth-1:0] be);
    logic [DataWidth-1:0] merged;
    for (int unsigned b = 0; b < StrbWidth; b++) begin
      merged[8*b +: 8] = be[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
    end
    return merged;
  endfunction

  // SRAM entry, pins held at the last table value, no interrupts expected
  function automatic vec_t sram_vec(input op_e op, input logic [AddrWidth-1:0] addr,
                                    input logic [DataWidth-1:0] wdata,
                                    input logic [StrbWidth-1:0] be,
                                    input logic [DataWidth-1:0] exp_rdata);
    vec_t v;
    v           = '0;
    v.op        = op;
    v.addr      = addr;
    v.wdata     = wdata;
    v.be        = be;
    v.gpio_in   = 16'h8001;
    v.exp_rdata = exp_rdata;
    v.obs       = ObsNone;
    return v;
  endfunction

  task automatic drive_vector(input vec_t v);
    bus_req.req   = (v.op != OpIdle);
    bus_req.we    = (v.op == OpWrite);
    bus_req.be    = v.be;
    bus_req.addr  = v.addr;
    bus_req.wdata = v.wdata;
    gpio_i        = v.gpio_in;
    irq_i         = v.irq_in;
    fetch_en_i    = v.fetch_en;
  endtask

  task automatic check_vector(input vec_t v);
    logic [DataWidth-1:0] obs_val;
    string                obs_name;
    assert (bus_rsp.gnt === bus_req.req)
      else report_mismatch("bus_rsp_o.gnt", DataWidth'(bus_req.req), DataWidth'(bus_rsp.gnt));
    assert (bus_rsp.rvalid === (v.op != OpIdle))
      else report_mismatch("bus_rsp_o.rvalid", DataWidth'(v.op != OpIdle),
                           DataWidth'(bus_rsp.rvalid));
    if (v.op != OpIdle) begin
      assert (bus_rsp.rdata === v.exp_rdata)
        else report_mismatch("bus_rsp_o.rdata", v.exp_rdata, bus_rsp.rdata);
      assert (bus_rsp.err === v.exp_err)
        else report_mismatch("bus_rsp_o.err", DataWidth'(v.exp_err), DataWidth'(bus_rsp.err));
    end
    assert (irqs_o === v.exp_irqs)
      else report_mismatch("irqs_o", DataWidth'(v.exp_irqs), DataWidth'(irqs_o));
    case (v.obs)
      ObsGpioOut: begin
        obs_val  = DataWidth'(gpio_o);
        obs_name = "gpio_o";
      end
      ObsGpioEn: begin
        obs_val  = DataWidth'(gpio_out_en_o);
        obs_name = "gpio_out_en_o";
      end
      ObsGpioSync: begin
        obs_val  = DataWidth'(gpio_in_sync_o);
        obs_name = "gpio_in_sync_o";
      end
      ObsBootAddr: begin
        obs_val  = boot_addr_o;
        obs_name = "boot_addr_o";
      end
      ObsFetchEn: begin
        obs_val  = DataWidth'(fetch_enable_o);
        obs_name = "fetch_enable_o";
      end
      default: begin
        obs_val  = '0;
        obs_name = "none";
      end
    endcase
    if (v.obs != ObsNone) begin
      assert (obs_val === v.exp_obs) else report_mismatch(obs_name, v.exp_obs, obs_val);
    end
  endtask

  // Response is due right after the accepting edge
  task automatic apply_vector(input vec_t v);
    drive_vector(v);
    @(posedge clk_i);
    #DriveDelay;
    check_vector(v);
  endtask

  // Write and read back on consecutive cycles, then a partial overwrite
  task automatic sram_random_pass();
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] full_data;
    logic [DataWidth-1:0] part_data;
    logic [StrbWidth-1:0] be;
    for (int unsigned k = 0; k < NumRandomWords; k++) begin
      addr      = SramBaseAddr + AddrWidth'((16 + 5 * k + $urandom_range(3, 0)) * 4);
      full_data = $urandom;
      part_data = $urandom;
      be        = StrbWidth'($urandom_range(15, 1));
      apply_vector(sram_vec(OpWrite, addr, full_data, 4'hF, '0));
      apply_vector(sram_vec(OpRead, addr, '0, '0, full_data));
      apply_vector(sram_vec(OpWrite, addr, part_data, be, '0));
      apply_vector(sram_vec(OpRead, addr, '0, '0, merge_bytes(full_data, part_data, be)));
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    void'($urandom(RandomSeed));
    clk_i      = 1'b0;
    rst_n_i    = 1'b0;
    fetch_en_i = 1'b0;
    bus_req    = '0;
    gpio_i     = '0;
    irq_i      = '0;
    repeat (ResetCycles) @(posedge clk_i);
    #DriveDelay;
    rst_n_i = 1'b1;
    foreach (vectors[i]) begin
      apply_vector(vectors[i]);
    end
    sram_random_pass();
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== verilog/err_sbr.sv ====
module err_sbr import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o
);

  logic rvalid_q;

  // Every access is granted, then answered with the error pattern
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = ErrRspData;
  // Flag only travels with an actual response
  assign rsp_o.err    = rvalid_q;

endmodule

// ==== verilog/periph_demux.sv ====
module periph_demux import soc_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  bus_req_t              mgr_req_i,
  output bus_rsp_t              mgr_rsp_o,
  output bus_req_t [NumSbr-1:0] sbr_req_o,
  input  bus_rsp_t [NumSbr-1:0] sbr_rsp_i
);

  sbr_idx_e sel_d;
  sbr_idx_e sel_q;
  logic     accept;

  function automatic logic in_region(input logic [AddrWidth-1:0] addr,
                                     input logic [AddrWidth-1:0] base,
                                     input logic [AddrWidth-1:0] size);
    return (addr >= base) && (addr < base + size);
  endfunction

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------
  always_comb begin
    sel_d = SbrError;
    if (in_region(mgr_req_i.addr, SramBaseAddr, SramSize)) begin
      sel_d = SbrSram;
    end else if (in_region(mgr_req_i.addr, SocCtrlBaseAddr, PeriphSize)) begin
      sel_d = SbrSocCtrl;
    end else if (in_region(mgr_req_i.addr, GpioBaseAddr, PeriphSize)) begin
      sel_d = SbrGpio;
    end else if (in_region(mgr_req_i.addr, TimerBaseAddr, PeriphSize)) begin
      sel_d = SbrTimer;
    end
  end

  // Only the addressed subordinate sees req high
  always_comb begin
    for (int unsigned i = 0; i < NumSbr; i++) begin
      sbr_req_o[i]     = mgr_req_i;
      sbr_req_o[i].req = mgr_req_i.req && (sel_d == sbr_idx_e'(i));
    end
  end

  // --------------------------------------------------------------------------
  // Response return path
  // --------------------------------------------------------------------------
  assign mgr_rsp_o.gnt = sbr_rsp_i[sel_d].gnt;
  assign accept        = mgr_req_i.req & mgr_rsp_o.gnt;

  // Remember who was addressed, the answer comes back next cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sel_q <= SbrError;
    end else if (accept) begin
      sel_q <= sel_d;
    end
  end

  assign mgr_rsp_o.rvalid = sbr_rsp_i[sel_q].rvalid;
  assign mgr_rsp_o.rdata  = sbr_rsp_i[sel_q].rdata;
  assign mgr_rsp_o.err    = sbr_rsp_i[sel_q].err;

endmodule

// ==== verilog/soc_ctrl.sv ====
module soc_ctrl import soc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  bus_req_t             req_i,
  output bus_rsp_t             rsp_o,
  input  logic                 fetch_en_i,
  output logic [AddrWidth-1:0] boot_addr_o,
  output logic                 fetch_enable_o
);

  logic [RegOffsetWidth-1:0] offset;
  logic [DataWidth-1:0]      wmask;
  logic                      wr_en;
  logic [AddrWidth-1:0]      boot_addr_q;
  logic                      fetch_en_q;
  logic [DataWidth-1:0]      read_data;
  logic [DataWidth-1:0]      rdata_q;
  logic                      rvalid_q;

  assign offset = req_i.addr[RegOffsetWidth-1:0];
  assign wmask  = be_to_mask(req_i.be);
  assign wr_en  = req_i.req & req_i.we;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      boot_addr_q <= SramBaseAddr;
      fetch_en_q  <= 1'b0;
    end else if (wr_en) begin
      case (offset)
        SocCtrlBootAddrOffset: boot_addr_q <= (boot_addr_q & ~wmask) | (req_i.wdata & wmask);
        SocCtrlFetchEnOffset: begin
          if (req_i.be[0]) fetch_en_q <= req_i.wdata[0];
        end
        default: ;
      endcase
    end
  end

  // Register read mux, unknown offsets read zero
  always_comb begin
    case (offset)
      SocCtrlBootAddrOffset: read_data = boot_addr_q;
      SocCtrlFetchEnOffset:  read_data = DataWidth'(fetch_en_q);
      default:               read_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) rdata_q <= req_i.we ? '0 : read_data;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) rvalid_q <= 1'b0;
    else          rvalid_q <= req_i.req;
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = 1'b0;

  assign boot_addr_o    = boot_addr_q;
  // Pin can start the core even with the register bit clear
  assign fetch_enable_o = fetch_en_q | fetch_en_i;

endmodule

// ==== verilog/soc_domain.sv ====
module soc_domain import soc_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       fetch_en_i,
  input  bus_req_t                   bus_req_i,
  output bus_rsp_t                   bus_rsp_o,
  input  logic [GpioCount-1:0]       gpio_i,
  output logic [GpioCount-1:0]       gpio_o,
  output logic [GpioCount-1:0]       gpio_out_en_o,
  output logic [GpioCount-1:0]       gpio_in_sync_o,
  output logic [AddrWidth-1:0]       boot_addr_o,
  output logic                       fetch_enable_o,
  input  logic [NumExternalIrqs-1:0] irq_i,
  output logic [NumIrqs-1:0]         irqs_o
);

  // One request and one response channel per subordinate, indexed by sbr_idx_e
  bus_req_t [NumSbr-1:0] sbr_req;
  bus_rsp_t [NumSbr-1:0] sbr_rsp;

  logic gpio_irq;
  logic timer_irq;

  // --------------------------------------------------------------------------
  // Interrupt vector
  // --------------------------------------------------------------------------
  always_comb begin
    irqs_o                                = '0;
    irqs_o[IrqTimer]                      = timer_irq;
    irqs_o[IrqGpio]                       = gpio_irq;
    irqs_o[IrqExtBase +: NumExternalIrqs] = irq_i;
  end

  // --------------------------------------------------------------------------
  // Decode and demux
  // --------------------------------------------------------------------------
  periph_demux i_periph_demux (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .mgr_req_i (bus_req_i),
    .mgr_rsp_o (bus_rsp_o),
    .sbr_req_o (sbr_req),
    .sbr_rsp_i (sbr_rsp)
  );

  // --------------------------------------------------------------------------
  // Subordinates
  // --------------------------------------------------------------------------
  err_sbr i_err_sbr (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (sbr_req[SbrError]),
    .rsp_o   (sbr_rsp[SbrError])
  );

  sram_bank i_sram_bank (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (sbr_req[SbrSram]),
    .rsp_o   (sbr_rsp[SbrSram])
  );

  soc_ctrl i_soc_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_i          (sbr_req[SbrSocCtrl]),
    .rsp_o          (sbr_rsp[SbrSocCtrl]),
    .fetch_en_i     (fetch_en_i),
    .boot_addr_o    (boot_addr_o),
    .fetch_enable_o (fetch_enable_o)
  );

  gpio i_gpio (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_i          (sbr_req[SbrGpio]),
    .rsp_o          (sbr_rsp[SbrGpio]),
    .gpio_i         (gpio_i),
    .gpio_o         (gpio_o),
    .gpio_out_en_o  (gpio_out_en_o),
    .gpio_in_sync_o (gpio_in_sync_o),
    .irq_o          (gpio_irq)
  );

  timer_unit i_timer (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (sbr_req[SbrTimer]),
    .rsp_o   (sbr_rsp[SbrTimer]),
    .irq_o   (timer_irq)
  );

endmodule

// ==== verilog/sram_bank.sv ====
module sram_bank import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o
);

  logic [DataWidth-1:0]    mem [SramNumWords];
  logic [SramIdxWidth-1:0] word_idx;
  logic [DataWidth-1:0]    rdata_q;
  logic                    rvalid_q;

  // Byte address to word index
  assign word_idx = req_i.addr[SramIdxWidth+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int unsigned b = 0; b < StrbWidth; b++) begin
          if (req_i.be[b]) begin
            mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = 1'b0;

endmodule
